// File: rtl/cksum_isa_pkg.sv
package cksum_isa_pkg;

   // Opcode in the top two bits of every command word
   typedef enum logic [1:0] {
      OP_WRITE = 2'b00,
      OP_SUM   = 2'b01,
      OP_ILL_A = 2'b10,
      OP_ILL_B = 2'b11
   } opcode_e;

   localparam int BODY_W = 30;

   // Write view of the command body
   typedef struct packed {
      logic [1:0]  wstrb;     // One strobe per byte of wdata
      logic [7:0]  waddr;     // 16-bit word address
      logic [3:0]  reserved;
      logic [15:0] wdata;
   } write_cmd_t;

   // Sum view of the command body
   typedef struct packed {
      logic [7:0]  start;     // First byte address
      logic [3:0]  len_m1;    // Byte count minus one
      logic [17:0] reserved;
   } sum_cmd_t;

   // Same 30 bits, decoded according to the opcode
   typedef union packed {
      write_cmd_t wr;
      sum_cmd_t   sm;
   } cmd_body_u;

   // Full 32-bit command as sent by the host
   typedef struct packed {
      opcode_e   op;
      cmd_body_u body;
   } cmd_word_t;

endpackage

// File: rtl/cksum_dp_pkg.sv
package cksum_dp_pkg;

   localparam int CSUM_W = 16;
   localparam int LEN_W  = 4;

   // Scratchpad write, one 16-bit word with byte strobes
   typedef struct packed {
      logic [1:0]  wstrb;
      logic [7:0]  waddr;
      logic [15:0] wdata;
   } wr_req_t;

   // Byte run to be summed
   typedef struct packed {
      logic [7:0]       start;
      logic [LEN_W-1:0] len_m1;
   } sum_req_t;

   // Accumulator and result value
   typedef logic [CSUM_W-1:0] csum_t;

endpackage

// File: rtl/cksum_regfile_2p.sv
`timescale 1ns/100ps

module cksum_regfile_2p #(
   parameter int W_DATA_W = 16,
   parameter int R_DATA_W = 8,
   // Address width of the narrow read port
   parameter int ADDR_W = 6,
   // Derived widths
   localparam int R        = W_DATA_W / R_DATA_W,
   localparam int R_LOG2   = $clog2(R),
   localparam int W_ADDR_W = ADDR_W - R_LOG2,
   localparam int WSTRB_W  = R,
   localparam int DEPTH    = 2 ** ADDR_W
) (
   input  logic                clk_i,
   input  logic                arst_i,
   input  logic                cke_i,

   // Wide write port
   input  logic [WSTRB_W-1:0]  wstrb_i,
   input  logic [W_ADDR_W-1:0] waddr_i,
   input  logic [W_DATA_W-1:0] wdata_i,

   // Narrow read port
   input  logic [ADDR_W-1:0]   raddr_i,
   output logic [R_DATA_W-1:0] rdata_o
);

   // One narrow entry per read address
   logic [DEPTH-1:0][R_DATA_W-1:0] mem;

   // Lane i of a write lands at waddr*R + i
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         mem <= '0;
      end else if (cke_i) begin
         for (int lane = 0; lane < R; lane++) begin
            if (wstrb_i[lane]) begin
               mem[{waddr_i, R_LOG2'(lane)}] <= wdata_i[lane*R_DATA_W +: R_DATA_W];
            end
         end
      end
   end

   // Combinational read
   assign rdata_o = mem[raddr_i];

   // A write strobe while stalled would be lost
   a_no_write_without_cke: assert property (
      @(posedge clk_i) disable iff (arst_i)
      !cke_i |-> (wstrb_i == '0)
   );

endmodule

// File: rtl/cmd_decode.sv
`timescale 1ns/100ps

module cmd_decode #(
   parameter int ADDR_W = 6
) (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  cksum_isa_pkg::cmd_word_t cmd_i,
   input  logic                     cmd_valid_i,
   input  logic                     busy_i,
   output cksum_dp_pkg::wr_req_t    wr_req_o,
   output logic                     wr_en_o,
   output cksum_dp_pkg::sum_req_t   sum_req_o,
   output logic                     sum_start_o,
   output logic                     drop_o,
   output logic                     illegal_o
);

   logic                      sum_pending;
   logic                      accept;
   logic                      is_write;
   logic                      is_sum;
   cksum_isa_pkg::write_cmd_t wr_view;
   cksum_isa_pkg::sum_cmd_t   sum_view;

   // Two views of the same body bits
   assign wr_view  = cmd_i.body.wr;
   assign sum_view = cmd_i.body.sm;

   assign is_write = (cmd_i.op == cksum_isa_pkg::OP_WRITE);
   assign is_sum   = (cmd_i.op == cksum_isa_pkg::OP_SUM);

   // Executor busy, or a start still on its way to it
   assign sum_pending = busy_i | sum_start_o;
   assign accept      = cmd_valid_i & ~sum_pending;

   // Strobes, one cycle after the command is sampled
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_en_o     <= 1'b0;
         sum_start_o <= 1'b0;
         drop_o      <= 1'b0;
         illegal_o   <= 1'b0;
      end else begin
         wr_en_o     <= accept & is_write;
         sum_start_o <= accept & is_sum;
         // Drop wins over illegal opcode
         drop_o      <= cmd_valid_i & sum_pending;
         illegal_o   <= accept & ~is_write & ~is_sum;
      end
   end

   // Payload, upper address bits and reserved bits ignored
   always_ff @(posedge clk_i) begin
      if (accept && is_write) begin
         wr_req_o.wstrb <= wr_view.wstrb;
         wr_req_o.waddr <= 8'(wr_view.waddr[ADDR_W-2:0]);
         wr_req_o.wdata <= wr_view.wdata;
      end
      if (accept && is_sum) begin
         sum_req_o.start  <= 8'(sum_view.start[ADDR_W-1:0]);
         sum_req_o.len_m1 <= sum_view.len_m1;
      end
   end

   // Each command ends in at most one outcome
   a_one_outcome: assert property (
      @(posedge clk_i) disable iff (arst_i)
      $onehot0({wr_en_o, sum_start_o, drop_o, illegal_o})
   );

endmodule

// File: rtl/sum_execute.sv
`timescale 1ns/100ps

module sum_execute #(
   parameter int ADDR_W = 6
) (
   input  logic                   clk_i,
   input  logic                   arst_i,
   input  cksum_dp_pkg::sum_req_t sum_req_i,
   input  logic                   sum_start_i,
   input  logic [7:0]             rd_byte_i,
   output logic [ADDR_W-1:0]      rd_addr_o,
   output logic                   busy_o,
   output cksum_dp_pkg::csum_t    acc_o,
   output logic                   acc_done_o
);

   localparam int CSUM_W = cksum_dp_pkg::CSUM_W;

   logic [cksum_dp_pkg::LEN_W-1:0] remain;
   logic [CSUM_W:0]                sum_wide;
   cksum_dp_pkg::csum_t            acc_next;

   // Byte goes into the low lane of the 16-bit sum
   assign sum_wide = {1'b0, acc_o} + {{(CSUM_W - 7){1'b0}}, rd_byte_i};

   // End-around carry, cannot overflow a second time
   assign acc_next = sum_wide[CSUM_W-1:0] + {{(CSUM_W - 1){1'b0}}, sum_wide[CSUM_W]};

   // Byte sequencer
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         busy_o     <= 1'b0;
         acc_done_o <= 1'b0;
         remain     <= '0;
         rd_addr_o  <= '0;
      end else begin
         acc_done_o <= 1'b0;
         if (sum_start_i) begin
            busy_o    <= 1'b1;
            remain    <= sum_req_i.len_m1;
            rd_addr_o <= sum_req_i.start[ADDR_W-1:0];
         end else if (busy_o) begin
            // Address wraps at the top of the scratchpad
            rd_addr_o <= rd_addr_o + ADDR_W'(1);
            remain    <= remain - 1'b1;
            if (remain == '0) begin
               // Last byte folded in on this edge
               busy_o     <= 1'b0;
               acc_done_o <= 1'b1;
            end
         end
      end
   end

   // Accumulator, cleared on start
   always_ff @(posedge clk_i) begin
      if (sum_start_i) begin
         acc_o <= '0;
      end else if (busy_o) begin
         acc_o <= acc_next;
      end
   end

   // Decode must never start a run on top of another one
   a_no_start_while_busy: assert property (
      @(posedge clk_i) disable iff (arst_i)
      sum_start_i |-> !busy_o
   );

endmodule

// File: rtl/cksum_result.sv
`timescale 1ns/100ps

module cksum_result (
   input  logic                clk_i,
   input  logic                arst_i,
   input  cksum_dp_pkg::csum_t acc_i,
   input  logic                acc_done_i,
   output cksum_dp_pkg::csum_t res_o,
   output logic                res_valid_o
);

   // Inverted sum, held until the next run finishes
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         res_o       <= '0;
         res_valid_o <= 1'b0;
      end else begin
         res_valid_o <= acc_done_i;
         if (acc_done_i) begin
            res_o <= ~acc_i;
         end
      end
   end

   // Result strobe is a single-cycle pulse
   a_single_pulse: assert property (
      @(posedge clk_i) disable iff (arst_i)
      res_valid_o |=> !res_valid_o
   );

endmodule

// File: rtl/cksum_engine_top.sv
`timescale 1ns/100ps

module cksum_engine_top #(
   parameter int ADDR_W = 6
) (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  cksum_isa_pkg::cmd_word_t cmd_i,
   input  logic                     cmd_valid_i,
   output cksum_dp_pkg::csum_t      res_o,
   output logic                     res_valid_o,
   output logic                     busy_o,
   output logic                     drop_o,
   output logic                     illegal_o
);

   cksum_dp_pkg::wr_req_t  wr_req;
   logic                   wr_en;
   cksum_dp_pkg::sum_req_t sum_req;
   logic                   sum_start;
   logic [1:0]             rf_wstrb;
   logic [ADDR_W-1:0]      rd_addr;
   logic [7:0]             rd_byte;
   cksum_dp_pkg::csum_t    acc;
   logic                   acc_done;

   // Strobes only count in the cycle wr_en is high
   assign rf_wstrb = wr_req.wstrb & {2{wr_en}};

   cmd_decode #(
      .ADDR_W (ADDR_W)
   ) u_decode (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .cmd_i       (cmd_i),
      .cmd_valid_i (cmd_valid_i),
      .busy_i      (busy_o),
      .wr_req_o    (wr_req),
      .wr_en_o     (wr_en),
      .sum_req_o   (sum_req),
      .sum_start_o (sum_start),
      .drop_o      (drop_o),
      .illegal_o   (illegal_o)
   );

   sum_execute #(
      .ADDR_W (ADDR_W)
   ) u_execute (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .sum_req_i   (sum_req),
      .sum_start_i (sum_start),
      .rd_byte_i   (rd_byte),
      .rd_addr_o   (rd_addr),
      .busy_o      (busy_o),
      .acc_o       (acc),
      .acc_done_o  (acc_done)
   );

   cksum_result u_result (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .acc_i       (acc),
      .acc_done_i  (acc_done),
      .res_o       (res_o),
      .res_valid_o (res_valid_o)
   );

   // No stall source, clock enable tied high
   cksum_regfile_2p #(
      .W_DATA_W (16),
      .R_DATA_W (8),
      .ADDR_W   (ADDR_W)
   ) u_regfile (
      .clk_i   (clk_i),
      .arst_i  (arst_i),
      .cke_i   (1'b1),
      .wstrb_i (rf_wstrb),
      .waddr_i (wr_req.waddr[ADDR_W-2:0]),
      .wdata_i (wr_req.wdata),
      .raddr_i (rd_addr),
      .rdata_o (rd_byte)
   );

endmodule

// File: sim/cksum_tb.sv
`timescale 1ns/100ps

module cksum_tb;

   localparam int ADDR_W = 6;
   localparam int DEPTH  = 2 ** ADDR_W;
   localparam int N_WR   = 24;
   // Commands over all tests, sizes the watchdog
   localparam int N_CMDS = 2 + (N_WR + 4) + 32 + 13 + 6;

   logic                     clk_i;
   logic                     arst_i;
   cksum_isa_pkg::cmd_word_t cmd_i;
   logic                     cmd_valid_i;
   cksum_dp_pkg::csum_t      res_o;
   logic                     res_valid_o;
   logic                     busy_o;
   logic                     drop_o;
   logic                     illegal_o;

   int                  cyc;
   int                  seed;
   int                  busy_lo;
   int                  busy_hi;
   int                  n_mismatch;
   int                  n_other;
   string               test_name;
   logic [7:0]          shadow [DEPTH];
   cksum_dp_pkg::csum_t last_res;
   cksum_dp_pkg::csum_t exp_res [$];
   int                  exp_edge [$];
   string               exp_name [$];
   int                  drop_edge [$];
   int                  ill_edge [$];

   cksum_engine_top #(
      .ADDR_W (ADDR_W)
   ) dut0 (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .cmd_i       (cmd_i),
      .cmd_valid_i (cmd_valid_i),
      .res_o       (res_o),
      .res_valid_o (res_valid_o),
      .busy_o      (busy_o),
      .drop_o      (drop_o),
      .illegal_o   (illegal_o)
   );

   // cyc counts rising edges
   initial begin
      clk_i = 1'b0;
      cyc   = 0;
      forever begin
         #4;
         clk_i = 1'b1;
         cyc   = cyc + 1;
         #4;
         clk_i = 1'b0;
      end
   end

   // Inverted 16-bit ones' complement sum over the shadow
   function automatic cksum_dp_pkg::csum_t ref_cksum(input logic [7:0] start,
                                                     input logic [3:0] len_m1);
      logic [16:0]       s;
      logic [ADDR_W-1:0] a;
      s = '0;
      a = start[ADDR_W-1:0];
      for (int i = 0; i <= int'(len_m1); i++) begin
         s = s + {9'd0, shadow[a]};
         if (s[16]) begin
            s = {1'b0, s[15:0]} + 17'd1;
         end
         a = a + ADDR_W'(1);
      end
      return ~s[15:0];
   endfunction

   function automatic cksum_isa_pkg::cmd_word_t write_word(input logic [1:0]  strb,
                                                           input logic [7:0]  waddr,
                                                           input logic [15:0] data,
                                                           input logic [3:0]  rsv);
      cksum_isa_pkg::cmd_word_t c;
      c.op               = cksum_isa_pkg::OP_WRITE;
      c.body.wr.wstrb    = strb;
      c.body.wr.waddr    = waddr;
      c.body.wr.reserved = rsv;
      c.body.wr.wdata    = data;
      return c;
   endfunction

   function automatic cksum_isa_pkg::cmd_word_t sum_word(input logic [7:0]  start,
                                                         input logic [3:0]  len_m1,
                                                         input logic [17:0] rsv);
      cksum_isa_pkg::cmd_word_t c;
      c.op               = cksum_isa_pkg::OP_SUM;
      c.body.sm.start    = start;
      c.body.sm.len_m1   = len_m1;
      c.body.sm.reserved = rsv;
      return c;
   endfunction

   function automatic cksum_isa_pkg::cmd_word_t odd_word(
         input cksum_isa_pkg::opcode_e           op,
         input logic [cksum_isa_pkg::BODY_W-1:0] body);
      cksum_isa_pkg::cmd_word_t c;
      c.op   = op;
      c.body = cksum_isa_pkg::cmd_body_u'(body);
      return c;
   endfunction

   task automatic check_csum(input string name, input cksum_dp_pkg::csum_t exp_v,
                             input cksum_dp_pkg::csum_t act_v);
      if (act_v !== exp_v) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp_v, act_v);
         n_mismatch++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v) begin
         $display("[ERROR] %s: expected %b, actual %b", name, exp_v, act_v);
         n_mismatch++;
      end
   endtask

   task automatic check_edge(input string name, input int exp_v, input int act_v);
      if (act_v != exp_v) begin
         $display("[ERROR] %s: expected edge %0d, actual edge %0d", name, exp_v, act_v);
         n_mismatch++;
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   // Called 1 ns after an edge, the command is sampled at the next one
   task automatic send_cmd(input cksum_isa_pkg::cmd_word_t c);
      int                e;
      logic [ADDR_W-2:0] w;
      e           = cyc + 1;
      cmd_i       = c;
      cmd_valid_i = 1'b1;
      if (e <= busy_hi + 1) begin
         drop_edge.push_back(e);
      end else if (c.op == cksum_isa_pkg::OP_WRITE) begin
         w = c.body.wr.waddr[ADDR_W-2:0];
         if (c.body.wr.wstrb[0]) begin
            shadow[{w, 1'b0}] = c.body.wr.wdata[7:0];
         end
         if (c.body.wr.wstrb[1]) begin
            shadow[{w, 1'b1}] = c.body.wr.wdata[15:8];
         end
      end else if (c.op == cksum_isa_pkg::OP_SUM) begin
         last_res = ref_cksum(c.body.sm.start, c.body.sm.len_m1);
         exp_res.push_back(last_res);
         exp_edge.push_back(e + int'(c.body.sm.len_m1) + 3);
         exp_name.push_back(test_name);
         // Busy after edges e+1 .. e+len_m1+1
         busy_lo = e + 1;
         busy_hi = e + int'(c.body.sm.len_m1) + 1;
      end else begin
         ill_edge.push_back(e);
      end
      @(posedge clk_i);
      #1;
      cmd_valid_i = 1'b0;
   endtask

   task automatic wait_idle();
      while (exp_res.size() != 0) begin
         idle(1);
      end
      idle(2);
   endtask

   // Compare process, samples mid-cycle
   initial begin : compare
      logic exp_flag;
      forever begin
         @(negedge clk_i);
         if (arst_i === 1'b0) begin
            check_flag({test_name, " busy_o"}, (cyc >= busy_lo) && (cyc <= busy_hi), busy_o);
            exp_flag = (drop_edge.size() != 0) && (drop_edge[0] == cyc);
            check_flag({test_name, " drop_o"}, exp_flag, drop_o);
            if (exp_flag) begin
               void'(drop_edge.pop_front());
            end
            exp_flag = (ill_edge.size() != 0) && (ill_edge[0] == cyc);
            check_flag({test_name, " illegal_o"}, exp_flag, illegal_o);
            if (exp_flag) begin
               void'(ill_edge.pop_front());
            end
            if (res_valid_o === 1'b1) begin
               if (exp_res.size() == 0) begin
                  $display("Result strobe with no SUM outstanding at edge %0d", cyc);
                  n_other++;
               end else begin
                  check_csum(exp_name[0], exp_res[0], res_o);
                  check_edge({exp_name[0], " timing"}, exp_edge[0], cyc);
                  void'(exp_res.pop_front());
                  void'(exp_edge.pop_front());
                  void'(exp_name.pop_front());
               end
            end else if (exp_edge.size() != 0 && exp_edge[0] < cyc) begin
               $display("Result strobe never came for a SUM in test %s", exp_name[0]);
               n_other++;
               void'(exp_res.pop_front());
               void'(exp_edge.pop_front());
               void'(exp_name.pop_front());
            end
         end
      end
   end

   initial begin : watchdog
      repeat (N_CMDS * 24 + 100) @(posedge clk_i);
      $display("Timeout: the tests did not finish in time");
      $display("Done: errors found");
      $finish;
   end

   initial begin : stimulus
      logic [31:0] r;
      seed        = 32'h312;
      arst_i      = 1'b1;
      cmd_i       = '0;
      cmd_valid_i = 1'b0;
      n_mismatch  = 0;
      n_other     = 0;
      busy_lo     = 0;
      busy_hi     = -10;
      last_res    = '0;
      shadow      = '{default: 8'h00};
      test_name   = "reset";
      repeat (2) @(posedge clk_i);
      #1;
      arst_i = 1'b0;

      // Quiet after reset, then sums over zeroed memory
      idle(4);
      check_csum("reset res_o", '0, res_o);
      send_cmd(sum_word(8'd0, 4'hf, 18'h0));
      wait_idle();
      send_cmd(sum_word(8'd60, 4'h7, 18'h0));
      wait_idle();

      // All four strobe patterns, upper address and reserved bits random
      test_name = "strobed write";
      for (int i = 0; i < N_WR; i++) begin
         r = $random(seed);
         send_cmd(write_word(2'(i % 4), r[7:0], r[31:16], r[11:8]));
      end
      for (int k = 0; k < 4; k++) begin
         send_cmd(sum_word(8'(k * 16), 4'hf, 18'h0));
         wait_idle();
      end

      test_name = "length";
      for (int k = 0; k < 16; k++) begin
         r = $random(seed);
         send_cmd(sum_word(r[7:0], 4'(k), r[29:12]));
         wait_idle();
      end
      test_name = "wrap";
      for (int k = 0; k < 16; k++) begin
         send_cmd(sum_word(8'(DEPTH - 1 - k / 2) | 8'h80, 4'(k), 18'h0));
         wait_idle();
      end

      // First one lands while sum_start is in flight
      test_name = "drop while busy";
      r = $random(seed);
      send_cmd(sum_word(8'd5, 4'hf, 18'h0));
      send_cmd(write_word(2'b11, 8'd3, r[15:0], 4'h0));
      send_cmd(sum_word(8'd0, 4'h0, 18'h0));
      send_cmd(odd_word(cksum_isa_pkg::OP_ILL_A, 30'h0));
      send_cmd(write_word(2'b01, 8'd2, r[31:16], 4'h0));
      send_cmd(sum_word(8'd40, 4'h3, 18'h0));
      send_cmd(write_word(2'b10, 8'd4, ~r[15:0], 4'h0));
      wait_idle();
      send_cmd(sum_word(8'd4, 4'h5, 18'h0));
      wait_idle();
      // Last dropped edge, then first accepted edge
      test_name = "busy boundary";
      send_cmd(sum_word(8'd20, 4'h3, 18'h0));
      idle(4);
      send_cmd(write_word(2'b11, 8'd10, r[31:16], 4'h0));
      send_cmd(sum_word(8'd20, 4'h1, 18'h0));
      wait_idle();
      send_cmd(write_word(2'b11, 8'd10, r[31:16], 4'h0));
      send_cmd(sum_word(8'd18, 4'h5, 18'h0));
      wait_idle();

      test_name = "illegal";
      r = $random(seed);
      send_cmd(odd_word(cksum_isa_pkg::OP_ILL_A, {2'b11, 8'h02, 4'h0, r[15:0]}));
      send_cmd(odd_word(cksum_isa_pkg::OP_ILL_B, {2'b11, 8'h03, 4'h0, r[31:16]}));
      idle(3);
      check_csum("illegal res_o", last_res, res_o);
      for (int k = 0; k < 4; k++) begin
         send_cmd(sum_word(8'(k * 16), 4'hf, 18'h0));
         wait_idle();
      end

      idle(4);
      if (exp_res.size() != 0 || drop_edge.size() != 0 || ill_edge.size() != 0) begin
         $display("Expected strobes still outstanding at the end of the run");
         n_other++;
      end
      $display("Errors: %0d value mismatches, %0d other failures", n_mismatch, n_other);
      if (n_mismatch == 0 && n_other == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: cksum_engine.f
rtl/cksum_isa_pkg.sv
rtl/cksum_dp_pkg.sv
rtl/cksum_regfile_2p.sv
rtl/cmd_decode.sv
rtl/sum_execute.sv
rtl/cksum_result.sv
rtl/cksum_engine_top.sv
sim/cksum_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := cksum_tb
FILELIST  := cksum_engine.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
